/* common/mousePkg.sv */
package mousePkg;

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////

    // one data byte off the wire
    typedef logic [7:0]  ps2Byte;
    // left, right, middle
    typedef logic [2:0]  buttonSet;
    // halved motion magnitude
    typedef logic [6:0]  motionMag;
    // screen column or row
    typedef logic [9:0]  cursorCoord;
    // idle cycle counter
    typedef logic [11:0] timeoutCount;
    // packet queue pointer and fill level
    typedef logic [1:0]  fifoPtr;
    typedef logic [2:0]  fifoLevel;

    // receiver states
    typedef enum logic [1:0] {idle, shifting, checking} rxState;
    // packet byte slots
    typedef enum logic [1:0] {waitButtons, waitX, waitY} asmState;

    //////////////////////////////////////////////////
    // screen and cursor geometry
    //////////////////////////////////////////////////

    localparam cursorCoord screenWidth  = 10'd640;
    localparam cursorCoord screenHeight = 10'd480;
    localparam cursorCoord cursorSize   = 10'd50;
    // cursor starts in the middle
    localparam cursorCoord startX = screenWidth >> 1;
    localparam cursorCoord startY = screenHeight >> 1;
    // keep the whole cursor on screen
    localparam cursorCoord maxX = screenWidth - cursorSize;
    localparam cursorCoord maxY = screenHeight - cursorSize;

    // quiet clk cycles before resync
    localparam timeoutCount timeoutCycles = 12'd3000;
    // packets held in the queue
    localparam fifoLevel fifoDepth = 3'd4;
    // start, 8 data, parity, stop
    localparam logic [3:0] ps2FrameBits = 4'd11;

endpackage

/* ps2/ps2Receiver.sv */
`timescale 1ns/100ps

module ps2Receiver (
    input  logic             clk,
    input  logic             rstn,
    input  logic             ps2Clk,
    input  logic             ps2Data,
    output mousePkg::ps2Byte rxByte,
    output logic             byteValid,
    output logic             frameError
);

    // two-flop synchronisers on both lines
    logic [1:0] clkSync;
    logic [1:0] dataSync;
    // delayed clock for edge detect
    logic clkPrev;
    logic clkFall;

    mousePkg::rxState      state;
    logic [3:0]            bitCount;
    // data, parity, stop after ten shifts
    logic [9:0]            shiftReg;
    mousePkg::timeoutCount idleCount;
    logic                  frameOk;

    //////////////////////////////////////////////////
    // synchronise and find falling edges
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            // lines idle high
            clkSync  <= 2'b11;
            dataSync <= 2'b11;
            clkPrev  <= 1'b1;
        end else begin
            clkSync  <= {clkSync[0], ps2Clk};
            dataSync <= {dataSync[0], ps2Data};
            clkPrev  <= clkSync[1];
        end
    end

    assign clkFall = clkPrev & ~clkSync[1];

    //////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////

    // odd parity over data plus parity bit, stop must be high
    assign frameOk   = (^shiftReg[8:0]) & shiftReg[9];
    assign rxByte    = shiftReg[7:0];
    // one cycle pulse while checking a good frame
    assign byteValid = (state == mousePkg::checking) & frameOk;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= mousePkg::idle;
            bitCount   <= 4'd0;
            idleCount  <= '0;
            frameError <= 1'b0;
        end else begin
            case (state)
                mousePkg::idle: begin
                    bitCount  <= 4'd0;
                    idleCount <= '0;
                    // start bit is low
                    if (clkFall && !dataSync[1]) begin
                        state    <= mousePkg::shifting;
                        bitCount <= 4'd1;
                    end
                end
                mousePkg::shifting: begin
                    if (clkFall) begin
                        idleCount <= '0;
                        bitCount  <= bitCount + 4'd1;
                        // stop bit just sampled
                        if (bitCount == mousePkg::ps2FrameBits - 4'd1) begin
                            state <= mousePkg::checking;
                        end
                    end else if (idleCount == mousePkg::timeoutCycles) begin
                        // clock went quiet mid frame
                        state      <= mousePkg::idle;
                        frameError <= 1'b1;
                    end else begin
                        idleCount <= idleCount + 12'd1;
                    end
                end
                mousePkg::checking: begin
                    // sticky error on bad parity or stop
                    if (!frameOk) begin
                        frameError <= 1'b1;
                    end
                    state <= mousePkg::idle;
                end
                default: state <= mousePkg::idle;
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == mousePkg::shifting && clkFall) begin
            shiftReg <= {dataSync[1], shiftReg[9:1]};
        end
    end

endmodule

/* packet/packetAssembler.sv */
`timescale 1ns/100ps

module packetAssembler (
    input  logic               clk,
    input  logic               rstn,
    input  mousePkg::ps2Byte   rxByte,
    input  logic               byteValid,
    input  logic               pktReady,
    output mousePkg::buttonSet pktButtons,
    output mousePkg::ps2Byte   pktX,
    output mousePkg::ps2Byte   pktY,
    output logic               pktValid,
    output logic               overflow
);

    mousePkg::asmState     state;
    mousePkg::buttonSet    btnReg;
    mousePkg::ps2Byte      xReg;
    mousePkg::timeoutCount idleCount;
    logic                  timedOut;
    // holding register empty or draining now
    logic                  holdFree;
    logic                  lastByte;
    logic                  loadPkt;

    assign timedOut = (idleCount == mousePkg::timeoutCycles);
    assign holdFree = ~pktValid | pktReady;
    assign lastByte = byteValid & (state == mousePkg::waitY);
    assign loadPkt  = lastByte & holdFree;

    //////////////////////////////////////////////////
    // byte slot FSM and idle counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= mousePkg::waitButtons;
            idleCount <= '0;
            pktValid  <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            case (state)
                mousePkg::waitButtons: begin
                    if (byteValid) state <= mousePkg::waitX;
                end
                mousePkg::waitX: begin
                    if (byteValid) state <= mousePkg::waitY;
                    else if (timedOut) state <= mousePkg::waitButtons;
                end
                mousePkg::waitY: begin
                    if (byteValid) state <= mousePkg::waitButtons;
                    else if (timedOut) state <= mousePkg::waitButtons;
                end
                default: state <= mousePkg::waitButtons;
            endcase

            // restart on every byte, hold at zero between packets
            if (byteValid || state == mousePkg::waitButtons) begin
                idleCount <= '0;
            end else if (!timedOut) begin
                idleCount <= idleCount + 12'd1;
            end

            // output handshake
            if (loadPkt) begin
                pktValid <= 1'b1;
            end else if (pktReady) begin
                pktValid <= 1'b0;
            end

            // previous packet still unsent, drop this one
            if (lastByte && !holdFree) begin
                overflow <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // payload
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (byteValid && state == mousePkg::waitButtons) begin
            btnReg <= rxByte[2:0];
        end
        if (byteValid && state == mousePkg::waitX) begin
            xReg <= rxByte;
        end
        if (loadPkt) begin
            pktButtons <= btnReg;
            pktX       <= xReg;
            pktY       <= rxByte;
        end
    end

endmodule

/* packet/packetFifo.sv */
`timescale 1ns/100ps

module packetFifo (
    input  logic               clk,
    input  logic               rstn,
    input  mousePkg::buttonSet pktButtons,
    input  mousePkg::ps2Byte   pktX,
    input  mousePkg::ps2Byte   pktY,
    input  logic               pktValid,
    input  logic               qReady,
    output logic               pktReady,
    output mousePkg::buttonSet qButtons,
    output mousePkg::ps2Byte   qX,
    output mousePkg::ps2Byte   qY,
    output logic               qValid
);

    // packet storage, one array per field
    mousePkg::buttonSet memButtons [mousePkg::fifoDepth];
    mousePkg::ps2Byte   memX       [mousePkg::fifoDepth];
    mousePkg::ps2Byte   memY       [mousePkg::fifoDepth];

    mousePkg::fifoPtr   wrPtr;
    mousePkg::fifoPtr   rdPtr;
    mousePkg::fifoLevel count;
    logic               full;
    logic               push;
    logic               pop;

    assign full   = (count == mousePkg::fifoDepth);
    assign qValid = (count != 3'd0);
    // a full queue still takes a packet while one leaves
    assign pktReady = ~full | qReady;

    assign push = pktValid & pktReady;
    assign pop  = qValid & qReady;

    // head of queue
    assign qButtons = memButtons[rdPtr];
    assign qX       = memX[rdPtr];
    assign qY       = memY[rdPtr];

    //////////////////////////////////////////////////
    // pointers and level
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            // pointers wrap naturally at depth 4
            if (push) wrPtr <= wrPtr + 2'd1;
            if (pop) rdPtr <= rdPtr + 2'd1;
            case ({push, pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            memButtons[wrPtr] <= pktButtons;
            memX[wrPtr]       <= pktX;
            memY[wrPtr]       <= pktY;
        end
    end

endmodule

/* verilog/cursorTracker.sv */
`timescale 1ns/100ps

module cursorTracker (
    input  logic                 clk,
    input  logic                 rstn,
    input  mousePkg::buttonSet   qButtons,
    input  mousePkg::ps2Byte     qX,
    input  mousePkg::ps2Byte     qY,
    input  logic                 qValid,
    input  logic                 reportReady,
    output logic                 qReady,
    output mousePkg::buttonSet   reportButtons,
    output mousePkg::cursorCoord cursorX,
    output mousePkg::cursorCoord cursorY,
    output logic                 reportValid
);

    mousePkg::motionMag   magX;
    mousePkg::motionMag   magY;
    mousePkg::cursorCoord nextX;
    mousePkg::cursorCoord nextY;
    logic                 accept;

    //////////////////////////////////////////////////
    // motion decode
    //////////////////////////////////////////////////

    // negate low seven bits when sign set, keep seven bits, then halve
    // so 0x80 comes out as zero
    function automatic mousePkg::motionMag halfMag(input mousePkg::ps2Byte motion);
        mousePkg::motionMag mag;
        mag = motion[7] ? (~motion[6:0] + 7'd1) : motion[6:0];
        return mag >> 1;
    endfunction

    // one axis step, saturating at 0 and limit
    function automatic mousePkg::cursorCoord stepCoord(
        input mousePkg::cursorCoord cur,
        input mousePkg::motionMag   mag,
        input logic                 grow,
        input mousePkg::cursorCoord limit
    );
        logic [10:0] sum;
        sum = {1'b0, cur} + {4'b0, mag};
        if (grow) begin
            return (sum > {1'b0, limit}) ? limit : sum[9:0];
        end
        // shrinking, floor at zero
        return ({3'b0, mag} > cur) ? 10'd0 : cur - {3'b0, mag};
    endfunction

    assign magX = halfMag(qX);
    assign magY = halfMag(qY);

    // positive x goes right
    assign nextX = stepCoord(cursorX, magX, ~qX[7], mousePkg::maxX);
    // positive y goes up, row number drops
    assign nextY = stepCoord(cursorY, magY, qY[7], mousePkg::maxY);

    //////////////////////////////////////////////////
    // report register
    //////////////////////////////////////////////////

    // take a packet when empty or emptying this cycle
    assign qReady = ~reportValid | reportReady;
    assign accept = qValid & qReady;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            reportValid   <= 1'b0;
            reportButtons <= '0;
            cursorX       <= mousePkg::startX;
            cursorY       <= mousePkg::startY;
        end else if (accept) begin
            reportValid   <= 1'b1;
            reportButtons <= qButtons;
            cursorX       <= nextX;
            cursorY       <= nextY;
        end else if (reportReady) begin
            reportValid <= 1'b0;
        end
    end

endmodule

/* verilog/mouseTop.sv */
`timescale 1ns/100ps

module mouseTop (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 ps2Clk,
    input  logic                 ps2Data,
    input  logic                 reportReady,
    output mousePkg::buttonSet   reportButtons,
    output mousePkg::cursorCoord cursorX,
    output mousePkg::cursorCoord cursorY,
    output logic                 reportValid,
    output logic                 overflow,
    output logic                 frameError
);

    // receiver to assembler
    mousePkg::ps2Byte   rxByte;
    logic               byteValid;

    // assembler to queue
    mousePkg::buttonSet pktButtons;
    mousePkg::ps2Byte   pktX;
    mousePkg::ps2Byte   pktY;
    logic               pktValid;
    logic               pktReady;

    // queue to tracker
    mousePkg::buttonSet qButtons;
    mousePkg::ps2Byte   qX;
    mousePkg::ps2Byte   qY;
    logic               qValid;
    logic               qReady;

    //////////////////////////////////////////////////
    // serial in, packets, queue, cursor
    //////////////////////////////////////////////////

    ps2Receiver receiver0 (
        .clk        (clk),
        .rstn       (rstn),
        .ps2Clk     (ps2Clk),
        .ps2Data    (ps2Data),
        .rxByte     (rxByte),
        .byteValid  (byteValid),
        .frameError (frameError)
    );

    packetAssembler assembler0 (
        .clk        (clk),
        .rstn       (rstn),
        .rxByte     (rxByte),
        .byteValid  (byteValid),
        .pktReady   (pktReady),
        .pktButtons (pktButtons),
        .pktX       (pktX),
        .pktY       (pktY),
        .pktValid   (pktValid),
        .overflow   (overflow)
    );

    packetFifo fifo0 (
        .clk        (clk),
        .rstn       (rstn),
        .pktButtons (pktButtons),
        .pktX       (pktX),
        .pktY       (pktY),
        .pktValid   (pktValid),
        .qReady     (qReady),
        .pktReady   (pktReady),
        .qButtons   (qButtons),
        .qX         (qX),
        .qY         (qY),
        .qValid     (qValid)
    );

    cursorTracker tracker0 (
        .clk           (clk),
        .rstn          (rstn),
        .qButtons      (qButtons),
        .qX            (qX),
        .qY            (qY),
        .qValid        (qValid),
        .reportReady   (reportReady),
        .qReady        (qReady),
        .reportButtons (reportButtons),
        .cursorX       (cursorX),
        .cursorY       (cursorY),
        .reportValid   (reportValid)
    );

endmodule

/* verif/mouseTbTasks.svh */
`ifndef MOUSE_TB_TASKS_SVH
`define MOUSE_TB_TASKS_SVH

//////////////////////////////////////////////////
// stimulus helpers
//////////////////////////////////////////////////

// advance n clocks, land just after the edge
task automatic waitCycles(input int n);
    repeat (n) @(posedge clk);
    #driveDelay;
endtask

// one PS/2 frame, start, data lsb first, odd parity, stop
task automatic sendPs2Byte(input logic [7:0] value, input bit badParity);
    logic [10:0] frame;
    int i;
    frame = {1'b1, (~^value) ^ badParity, value, 1'b0};
    for (i = 0; i < 11; i++) begin
        // data settles while the line clock is high
        ps2Data = frame[i];
        waitCycles(ps2Half);
        ps2Clk = 1'b0;
        waitCycles(ps2Half);
        ps2Clk = 1'b1;
    end
    ps2Data = 1'b1;
    // gap before the next byte
    waitCycles(byteGap);
endtask

// button byte, x byte, y byte
// counted packets go into the model before they are sent
task automatic sendPacket(
    input logic [2:0] buttons,
    input logic [7:0] moveX,
    input logic [7:0] moveY,
    input bit         counted
);
    if (counted) begin
        expectReport(buttons, moveX, moveY);
    end
    // bit 3 always set, sign copies in bits 4 and 5
    sendPs2Byte({2'b00, moveY[7], moveX[7], 1'b1, buttons}, 1'b0);
    sendPs2Byte(moveX, 1'b0);
    sendPs2Byte(moveY, 1'b0);
endtask

// block until every expected report has come out
task automatic waitForReports();
    while (expectQ.size() != 0) begin
        @(posedge clk);
    end
    #driveDelay;
    waitCycles(20);
endtask

//////////////////////////////////////////////////
// random numbers and checking
//////////////////////////////////////////////////

// 32 bit xorshift, 13 / 17 / 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

task automatic checkValue(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
        $display("[FAIL] %s / %s: expected %0d, actual %0d",
                 currentTest, what, expected, actual);
        stopWithFailure();
    end
endtask

`endif

/* verif/mouseTb.sv */
`timescale 1ns/100ps

module mouseTb;

    // stimulus timing in clk cycles
    localparam int driveDelay = 10;
    localparam int ps2Half    = 10;
    localparam int byteGap    = 20;
    localparam int frameCycles  = 11 * 2 * ps2Half + byteGap;
    localparam int packetCycles = 3 * frameCycles;
    // longer than the 3000 cycle resync
    localparam int idleGap = 3500;
    // 60 packets, 5 loose bytes, 2 idle gaps, some settling
    localparam int runCycles  = 60 * packetCycles + 5 * frameCycles + 2 * idleGap + 1000;
    localparam int cycleLimit = runCycles + runCycles / 2;

    // cursor limits for a 50 pixel cursor on 640 x 480
    localparam int maxCol = 640 - 50;
    localparam int maxRow = 480 - 50;

    logic clk;
    logic rstn;
    logic ps2Clk;
    logic ps2Data;
    logic reportReady;
    mousePkg::buttonSet   reportButtons;
    mousePkg::cursorCoord cursorX;
    mousePkg::cursorCoord cursorY;
    logic reportValid;
    logic overflow;
    logic frameError;

    // {buttons, column, row} per expected report
    logic [22:0] expectQ [$];
    logic [22:0] headReport;
    string       currentTest;
    logic [31:0] rngState;
    int modelX;
    int modelY;
    int expectedTotal;
    int reportCount;
    int lastX;
    int lastY;
    int cycleCount;
    int pktIndex;
    int reportsBefore;

    mouseTop dut0 (
        .clk           (clk),
        .rstn          (rstn),
        .ps2Clk        (ps2Clk),
        .ps2Data       (ps2Data),
        .reportReady   (reportReady),
        .reportButtons (reportButtons),
        .cursorX       (cursorX),
        .cursorY       (cursorY),
        .reportValid   (reportValid),
        .overflow      (overflow),
        .frameError    (frameError)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopWithFailure();
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // two's complement of the low seven bits when negative, wraps to 7 bits,
    // then halved; rows count downward so y moves the other way
    function automatic int expectCoord(input int cur, input logic [7:0] motion,
                                       input bit rowAxis, input int limit);
        int mag;
        int delta;
        int pos;
        mag = motion[7] ? ((128 - int'(motion[6:0])) % 128) : int'(motion[6:0]);
        mag = mag / 2;
        delta = motion[7] ? -mag : mag;
        if (rowAxis) delta = -delta;
        pos = cur + delta;
        if (pos < 0) pos = 0;
        if (pos > limit) pos = limit;
        return pos;
    endfunction

    task automatic expectReport(input logic [2:0] buttons, input logic [7:0] moveX,
                                input logic [7:0] moveY);
        modelX = expectCoord(modelX, moveX, 1'b0, maxCol);
        modelY = expectCoord(modelY, moveY, 1'b1, maxRow);
        expectQ.push_back({buttons, modelX[9:0], modelY[9:0]});
        expectedTotal++;
    endtask

    `include "mouseTbTasks.svh"

    // sample mid cycle, a transfer happens at the next rising edge
    always @(negedge clk) begin
        if (rstn && reportValid && reportReady) begin
            if (expectQ.size() == 0) begin
                $display("report at (%0d, %0d) arrived with no packet pending",
                         cursorX, cursorY);
                stopWithFailure();
            end else begin
                headReport = expectQ.pop_front();
                checkValue("buttons", headReport[22:20], reportButtons);
                checkValue("cursorX", headReport[19:10], cursorX);
                checkValue("cursorY", headReport[9:0], cursorY);
                lastX = cursorX;
                lastY = cursorY;
                reportCount++;
            end
        end
    end

    // run length guard
    always @(posedge clk) begin
        if (cycleCount == cycleLimit) begin
            $display("simulation timed out after %0d cycles", cycleCount);
            stopWithFailure();
        end else begin
            cycleCount++;
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        rstn          = 1'b0;
        ps2Clk        = 1'b1;
        ps2Data       = 1'b1;
        reportReady   = 1'b1;
        rngState      = 32'd61;
        modelX        = 640 / 2;
        modelY        = 480 / 2;
        expectedTotal = 0;
        reportCount   = 0;
        cycleCount    = 0;
        lastX         = modelX;
        lastY         = modelY;
        currentTest   = "reset";
        repeat (4) @(posedge clk);
        #driveDelay;
        rstn = 1'b1;
        waitCycles(2);

        // idle state after reset
        checkValue("reportValid", 0, reportValid);
        checkValue("overflow", 0, overflow);
        checkValue("frameError", 0, frameError);
        checkValue("cursorX", 320, cursorX);
        checkValue("cursorY", 240, cursorY);
        checkValue("reportButtons", 0, reportButtons);

        currentTest = "random packets";
        for (pktIndex = 0; pktIndex < 30; pktIndex++) begin
            rngState = xorshift32(rngState);
            sendPacket(rngState[2:0], rngState[15:8], rngState[23:16], 1'b1);
        end
        waitForReports();

        currentTest = "limits";
        // minus 128 wraps to zero motion
        reportsBefore = lastX;
        sendPacket(3'b000, 8'h80, 8'h80, 1'b1);
        waitForReports();
        checkValue("0x80 column", reportsBefore, lastX);
        // right and top
        for (pktIndex = 0; pktIndex < 10; pktIndex++) begin
            sendPacket(3'b001, 8'h7f, 8'h7f, 1'b1);
        end
        waitForReports();
        checkValue("right limit", 590, lastX);
        checkValue("top limit", 0, lastY);
        // left and bottom
        for (pktIndex = 0; pktIndex < 10; pktIndex++) begin
            sendPacket(3'b010, 8'h81, 8'h81, 1'b1);
        end
        waitForReports();
        checkValue("left limit", 0, lastX);
        checkValue("bottom limit", 430, lastY);

        currentTest = "parity error";
        checkValue("frameError before", 0, frameError);
        // button and x bytes, then a bad byte in the y slot
        sendPs2Byte(8'h09, 1'b0);
        sendPs2Byte(8'h10, 1'b0);
        sendPs2Byte(8'h20, 1'b1);
        checkValue("frameError", 1, frameError);
        // a packet built from the bad byte would hit an empty expect queue
        waitCycles(idleGap);
        sendPacket(3'b100, 8'h20, 8'he0, 1'b1);
        waitForReports();

        currentTest = "partial packet";
        sendPs2Byte(8'h0b, 1'b0);
        sendPs2Byte(8'h55, 1'b0);
        waitCycles(idleGap);
        sendPacket(3'b011, 8'hf0, 8'h10, 1'b1);
        waitForReports();

        currentTest = "back-pressure";
        checkValue("overflow before", 0, overflow);
        reportReady = 1'b0;
        // report, four queued, one held, the seventh is lost
        for (pktIndex = 0; pktIndex < 7; pktIndex++) begin
            rngState = xorshift32(rngState);
            sendPacket(rngState[2:0], rngState[15:8], rngState[23:16], pktIndex < 6);
        end
        checkValue("overflow", 1, overflow);
        checkValue("report held", 1, reportValid);
        reportReady = 1'b1;
        waitForReports();
        // room for a stray seventh report to show up
        waitCycles(100);

        if (expectQ.size() == 0 && reportCount == expectedTotal) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("%0d of %0d expected reports never came out",
                     expectedTotal - reportCount, expectedTotal);
            stopWithFailure();
        end
    end

endmodule

/* project.f */
+incdir+verif
common/mousePkg.sv
ps2/ps2Receiver.sv
packet/packetAssembler.sv
packet/packetFifo.sv
verilog/cursorTracker.sv
verilog/mouseTop.sv
verif/mouseTb.sv
